/* bench/cpu_tb.sv */
`default_nettype none

module cpu_tb;
  import cpu_pkg::*;

  typedef struct packed {
    logic      vram;
    ram_addr_t addr;
    data_t     data;
  } write_t;

  logic        clk;
  logic        rst_n;
  data_t       dout;
  data_t       din;
  data_t       v_din;
  ram_addr_t   ada;
  ram_addr_t   adb;
  vram_addr_t  v_ada;
  logic        cea;
  logic        ceb;
  logic        v_cea;

  // Memory image with program and data for the model
  data_t       image [0:8191];
  write_t      expected [$];
  write_t      want;
  logic [31:0] lfsr = 32'h78bc;
  addr_t       wp;
  data_t       reg_a;
  data_t       reg_x;
  data_t       reg_y;
  int          total;

  cpu_top uut (
    .clk   (clk),
    .rst_n (rst_n),
    .dout  (dout),
    .din   (din),
    .ada   (ada),
    .cea   (cea),
    .ceb   (ceb),
    .adb   (adb),
    .v_ada (v_ada),
    .v_cea (v_cea),
    .v_din (v_din)
  );

  tb_memory mem (
    .clk   (clk),
    .adb   (adb),
    .dout  (dout),
    .ada   (ada),
    .cea   (cea),
    .din   (din),
    .v_ada (v_ada),
    .v_cea (v_cea),
    .v_din (v_din)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic stop_with_error(input string why);
    $display("%s", why);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] exp_val);
    stop_with_error($sformatf("Mismatch on %s: got 0x%0h, expected 0x%0h",
                              name, got, exp_val));
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output data_t b);
    b = 8'h00;
    for (int i = 0; i < 8; i++) begin
      lfsr = lfsr_step(lfsr);
      b = {b[6:0], lfsr[0]};
    end
  endtask

  task automatic put_byte(input data_t b);
    image[wp[12:0]] = b;
    wp = wp + 16'd1;
  endtask

  // Little endian operand
  task automatic put_word(input addr_t w);
    put_byte(w[7:0]);
    put_byte(w[15:8]);
  endtask

  task automatic set_reg(input target_t r, input data_t v);
    case (r)
      A: reg_a = v;
      X: reg_x = v;
      default: reg_y = v;
    endcase
  endtask

  task automatic expect_write(input logic vram, input ram_addr_t addr);
    write_t w;
    w.vram = vram;
    w.addr = addr;
    w.data = reg_a;
    expected.push_back(w);
  endtask

  task automatic load_imm(input data_t op, input target_t r, input data_t v);
    put_byte(op);
    put_byte(v);
    set_reg(r, v);
  endtask

  task automatic load_zp(input data_t op, input target_t r, input data_t zp);
    put_byte(op);
    put_byte(zp);
    set_reg(r, image[13'(zp)]);
  endtask

  task automatic load_abs(input data_t op, input target_t r, input addr_t base,
                          input data_t idx);
    addr_t ea;
    put_byte(op);
    put_word(base);
    ea = base + 16'(idx);
    set_reg(r, image[ea[12:0]]);
  endtask

  // Zero page index wraps at 8 bits
  task automatic store_zp(input data_t op, input data_t zp, input data_t idx);
    data_t zp_ea;
    put_byte(op);
    put_byte(zp);
    zp_ea = zp + idx;
    expect_write(1'b0, 13'(zp_ea));
  endtask

  // VRAM at and above E000 and RAM cut to 13 bits below
  task automatic store_abs(input data_t op, input addr_t base, input data_t idx);
    addr_t ea;
    addr_t off;
    put_byte(op);
    put_word(base);
    ea = base + 16'(idx);
    off = ea - 16'hE000;
    if (ea >= 16'hE000) begin
      expect_write(1'b1, 13'(off[9:0]));
    end else begin
      expect_write(1'b0, ea[12:0]);
    end
  endtask

  task automatic build_program();
    data_t r;
    data_t r2;
    addr_t loop_pc;
    int    mark;
    int    last;
    for (int i = 0; i < 8192; i++) begin
      image[i] = 8'(i) ^ 8'(i >> 5) ^ 8'h3c;
    end
    for (int i = 'h10; i < 'h20; i++) begin
      rand_byte(r);
      image[i] = r;
    end
    for (int i = 'h1000; i < 'h1200; i++) begin
      rand_byte(r);
      image[i] = r;
    end
    // Large X so that C0 plus X wraps in page zero
    image[13'h0010][7] = 1'b1;
    wp = 16'h0200;

    // Immediate load followed by zero page and VRAM stores
    rand_byte(r);
    load_imm(8'hA9, A, r);
    rand_byte(r);
    store_zp(8'h85, {2'b01, r[5:0]}, 8'h00);
    rand_byte(r);
    rand_byte(r2);
    store_abs(8'h8D, 16'hE000 + {6'b0, r[1:0], r2}, 8'h00);

    // Zero page and absolute loads feeding indexed stores
    load_zp(8'hA6, X, 8'h10);
    load_abs(8'hAC, Y, 16'h1000, 8'h00);
    load_zp(8'hA5, A, 8'h11);
    store_zp(8'h95, 8'hC0, reg_x);
    load_abs(8'hAD, A, 16'h1001, 8'h00);
    store_abs(8'h99, 16'h1E80, reg_y);
    load_abs(8'hAE, X, 16'h1002, 8'h00);
    load_zp(8'hA4, Y, 8'h12);
    store_zp(8'h95, 8'h30, reg_x);
    store_abs(8'h99, 16'h1C00, reg_y);

    // Indexed loads across page boundaries
    rand_byte(r);
    load_imm(8'hA2, X, r);
    rand_byte(r);
    load_imm(8'hA0, Y, r);
    load_abs(8'hBD, A, 16'h10F0, reg_x);
    store_abs(8'h8D, 16'h1D00, 8'h00);
    load_abs(8'hBE, X, 16'h1080, reg_y);
    load_abs(8'hBC, Y, 16'h1100, reg_x);
    load_abs(8'hB9, A, 16'h1040, reg_y);
    store_abs(8'h9D, 16'h7FC0, reg_x);

    // Store block entered twice through the final JMP
    mark = expected.size();
    loop_pc = wp;
    rand_byte(r);
    rand_byte(r2);
    store_abs(8'h8D, 16'hE000 + {6'b0, r[1:0], r2}, 8'h00);
    put_byte(8'hEA);
    put_byte(8'hFF);
    store_zp(8'h95, 8'hF8, reg_x);
    store_abs(8'h99, 16'hDFF0, reg_y);
    put_byte(8'h4C);
    put_word(loop_pc);
    last = expected.size();
    for (int i = mark; i < last; i++) begin
      expected.push_back(expected[i]);
    end
    total = expected.size();
  endtask

  task automatic check_idle();
    assert (!cea && !v_cea) else stop_with_error("A write enable is high around reset");
    assert (adb == 13'h0200) else report_mismatch("adb", 32'(adb), 32'h0200);
    assert (ceb) else report_mismatch("ceb", 32'(ceb), 32'h1);
  endtask

  // Write checker sampling in the middle of the cycle
  always @(negedge clk) begin
    if (cea || v_cea) begin
      assert (expected.size() > 0) else stop_with_error("A write happened with none expected");
      assert (!(cea && v_cea)) else stop_with_error("RAM and VRAM writes happened together");
      want = expected.pop_front();
      assert (v_cea == want.vram) else report_mismatch("v_cea", 32'(v_cea), 32'(want.vram));
      if (want.vram) begin
        assert (13'(v_ada) == want.addr) else report_mismatch("v_ada", 32'(v_ada), 32'(want.addr));
        assert (v_din == want.data) else report_mismatch("v_din", 32'(v_din), 32'(want.data));
      end else begin
        assert (ada == want.addr) else report_mismatch("ada", 32'(ada), 32'(want.addr));
        assert (din == want.data) else report_mismatch("din", 32'(din), 32'(want.data));
      end
    end
  end

  initial begin
    int waited;
    int left;
    rst_n = 1'b0;
    build_program();
    for (int i = 0; i < 8192; i++) begin
      mem.ram[i] = image[i];
    end
    @(posedge clk);
    @(negedge clk);
    check_idle();
    @(posedge clk);
    #1;
    rst_n = 1'b1;
    @(negedge clk);
    check_idle();
    while (expected.size() > 0) begin
      left = expected.size();
      waited = 0;
      while (expected.size() == left) begin
        @(posedge clk);
        waited++;
        if (waited > 200) begin
          stop_with_error("Timeout, no write seen within 200 cycles");
        end
      end
    end
    @(negedge clk);
    $display("Writes seen: %0d RAM, %0d VRAM", mem.ram_writes, mem.vram_writes);
    if (mem.ram_writes + mem.vram_writes == total) begin
      $display("NO ERRORS");
      $finish;
    end else begin
      stop_with_error("Memory model saw a different number of writes than expected");
    end
  end

endmodule

`default_nettype wire

/* bench/tb_memory.sv */
`default_nettype none

module tb_memory (
  input  logic                clk,
  input  cpu_pkg::ram_addr_t  adb,
  output cpu_pkg::data_t      dout,
  input  cpu_pkg::ram_addr_t  ada,
  input  logic                cea,
  input  cpu_pkg::data_t      din,
  input  cpu_pkg::vram_addr_t v_ada,
  input  logic                v_cea,
  input  cpu_pkg::data_t      v_din
);
  import cpu_pkg::*;

  data_t ram  [0:(1 << RAM_WIDTH) - 1];
  data_t vram [0:(1 << VRAM_WIDTH) - 1];
  data_t rd_q;

  // Write counts read by the testbench at the end of the run
  int    ram_writes = 0;
  int    vram_writes = 0;

  initial begin
    dout = 8'h00;
  end

  // Read before write with read data shortly after the edge
  always @(posedge clk) begin
    rd_q = ram[adb];
    if (cea) begin
      ram[ada] = din;
      ram_writes++;
    end
    if (v_cea) begin
      vram[v_ada] = v_din;
      vram_writes++;
    end
    #1;
    dout = rd_q;
  end

endmodule

`default_nettype wire

/* filelist.f */
source/cpu_pkg.sv
source/cpu_control.sv
source/pc_unit.sv
source/register_file.sv
source/address_unit.sv
source/cpu_top.sv
bench/tb_memory.sv
bench/cpu_tb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpu_tb -f filelist.f -o cpu_sim

if ./obj_dir/cpu_sim | tee /dev/stderr | grep -x "NO ERRORS" > /dev/null; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi

/* source/address_unit.sv */
`default_nettype none

module address_unit (
  input  logic                clk,
  input  logic                rst_n,
  input  cpu_pkg::data_t      dout,
  input  logic                op_lo_load,
  input  logic                op_hi_load,
  input  logic                rd_sel,
  input  logic                store_go,
  input  cpu_pkg::addr_mode_t mode,
  input  cpu_pkg::addr_t      pc,
  input  cpu_pkg::data_t      a,
  input  cpu_pkg::data_t      x,
  input  cpu_pkg::data_t      y,
  output cpu_pkg::ram_addr_t  adb,
  output cpu_pkg::addr_t      target,
  output cpu_pkg::ram_wr_t    ram_wr,
  output cpu_pkg::vram_wr_t   vram_wr
);
  import cpu_pkg::*;

  data_t      op_lo;
  data_t      op_hi;
  addr_t      abs_addr;
  addr_t      vram_off;
  logic       to_vram;
  logic       ram_en;
  logic       vram_en;
  ram_addr_t  ram_addr;
  vram_addr_t vram_addr;
  data_t      wr_data;

  // Operand bytes arrive little endian
  always_ff @(posedge clk) begin
    if (op_lo_load) begin
      op_lo <= dout;
    end
    if (op_hi_load) begin
      op_hi <= dout;
    end
  end

  assign abs_addr = {op_hi, op_lo};

  always_comb begin
    case (mode)
      IMM, ZP: target = {8'h00, op_lo};
      // Zero page index wraps inside page zero
      ZP_X:    target = {8'h00, 8'(op_lo + x)};
      ABS_X:   target = abs_addr + addr_t'(x);
      ABS_Y:   target = abs_addr + addr_t'(y);
      default: target = abs_addr;
    endcase
  end

  assign adb = rd_sel ? target[RAM_WIDTH-1:0] : pc[RAM_WIDTH-1:0];

  // Store routing by memory map
  assign to_vram  = (target >= VRAM_START);
  assign vram_off = target - VRAM_START;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ram_en  <= 1'b0;
      vram_en <= 1'b0;
    end else begin
      ram_en  <= store_go && !to_vram;
      vram_en <= store_go && to_vram;
    end
  end

  always_ff @(posedge clk) begin
    if (store_go) begin
      ram_addr  <= target[RAM_WIDTH-1:0];
      vram_addr <= vram_off[VRAM_WIDTH-1:0];
      wr_data   <= a;
    end
  end

  assign ram_wr  = '{en: ram_en, addr: ram_addr, data: wr_data};
  assign vram_wr = '{en: vram_en, addr: vram_addr, data: wr_data};

endmodule

`default_nettype wire

/* source/cpu_control.sv */
`default_nettype none

module cpu_control (
  input  logic            clk,
  input  logic            rst_n,
  input  cpu_pkg::data_t  dout,
  output cpu_pkg::decode_t dec,
  output logic [1:0]      pc_step,
  output logic            pc_jump,
  output logic            op_lo_load,
  output logic            op_hi_load,
  output logic            reg_load,
  output logic            rd_sel,
  output logic            store_go
);
  import cpu_pkg::*;

  fetch_stage_t stage;
  // Which RECV stage follows the current byte read
  fetch_stage_t next_recv;
  data_t        opcode;
  decode_t      fresh;

  function automatic decode_t make_dec(addr_mode_t mode, target_t tgt,
                                       logic store, logic jump);
    decode_t d;
    d.mode     = mode;
    d.target   = tgt;
    d.is_store = store;
    d.is_jump  = jump;
    if (mode == IMPLIED) begin
      d.length = 2'd1;
    end else if (mode inside {IMM, ZP, ZP_X}) begin
      d.length = 2'd2;
    end else begin
      d.length = 2'd3;
    end
    return d;
  endfunction

  function automatic decode_t decode(data_t op);
    decode_t d;
    case (op)
      OP_JMP_ABS:   d = make_dec(ABS, NONE, 1'b0, 1'b1);
      OP_LDA_IMM:   d = make_dec(IMM, A, 1'b0, 1'b0);
      OP_LDA_ZP:    d = make_dec(ZP, A, 1'b0, 1'b0);
      OP_LDA_ABS:   d = make_dec(ABS, A, 1'b0, 1'b0);
      OP_LDA_ABS_X: d = make_dec(ABS_X, A, 1'b0, 1'b0);
      OP_LDA_ABS_Y: d = make_dec(ABS_Y, A, 1'b0, 1'b0);
      OP_LDX_IMM:   d = make_dec(IMM, X, 1'b0, 1'b0);
      OP_LDX_ZP:    d = make_dec(ZP, X, 1'b0, 1'b0);
      OP_LDX_ABS:   d = make_dec(ABS, X, 1'b0, 1'b0);
      OP_LDX_ABS_Y: d = make_dec(ABS_Y, X, 1'b0, 1'b0);
      OP_LDY_IMM:   d = make_dec(IMM, Y, 1'b0, 1'b0);
      OP_LDY_ZP:    d = make_dec(ZP, Y, 1'b0, 1'b0);
      OP_LDY_ABS:   d = make_dec(ABS, Y, 1'b0, 1'b0);
      OP_LDY_ABS_X: d = make_dec(ABS_X, Y, 1'b0, 1'b0);
      OP_STA_ZP:    d = make_dec(ZP, NONE, 1'b1, 1'b0);
      OP_STA_ZP_X:  d = make_dec(ZP_X, NONE, 1'b1, 1'b0);
      OP_STA_ABS:   d = make_dec(ABS, NONE, 1'b1, 1'b0);
      OP_STA_ABS_X: d = make_dec(ABS_X, NONE, 1'b1, 1'b0);
      OP_STA_ABS_Y: d = make_dec(ABS_Y, NONE, 1'b1, 1'b0);
      OP_NOP:       d = make_dec(IMPLIED, NONE, 1'b0, 1'b0);
      // Unknown opcodes run as one-byte no-ops
      default:      d = make_dec(IMPLIED, NONE, 1'b0, 1'b0);
    endcase
    return d;
  endfunction

  // Opcode on the bus in RECV_OPCODE, latched copy afterwards
  assign fresh = decode(dout);
  assign dec   = decode(opcode);

  // Data reads use the effective address
  assign rd_sel = (next_recv == RECV_DATA);

  always_comb begin
    pc_step    = 2'd0;
    pc_jump    = 1'b0;
    op_lo_load = 1'b0;
    op_hi_load = 1'b0;
    reg_load   = 1'b0;
    store_go   = 1'b0;
    case (stage)
      RECV_OPCODE: pc_step = 2'd1;
      RECV_OP_LO: begin
        pc_step    = 2'd1;
        op_lo_load = 1'b1;
      end
      RECV_OP_HI: begin
        pc_step    = 2'd1;
        op_hi_load = 1'b1;
      end
      RECV_DATA: reg_load = 1'b1;
      EXECUTE: begin
        pc_jump  = dec.is_jump;
        store_go = dec.is_store;
        // Only immediate loads finish here
        reg_load = (dec.target != NONE);
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      stage     <= FETCH_REQ;
      next_recv <= RECV_OPCODE;
      opcode    <= OP_NOP;
    end else begin
      case (stage)
        FETCH_REQ: stage <= WAIT_DATA;
        WAIT_DATA: stage <= next_recv;
        RECV_OPCODE: begin
          opcode    <= dout;
          stage     <= FETCH_REQ;
          next_recv <= (fresh.length == 2'd1) ? RECV_OPCODE : RECV_OP_LO;
        end
        RECV_OP_LO: begin
          if (dec.length == 2'd3) begin
            next_recv <= RECV_OP_HI;
            stage     <= FETCH_REQ;
          end else if (dec.mode == IMM || dec.is_store) begin
            stage <= EXECUTE;
          end else begin
            next_recv <= RECV_DATA;
            stage     <= FETCH_REQ;
          end
        end
        RECV_OP_HI: begin
          if (dec.is_store || dec.is_jump) begin
            stage <= EXECUTE;
          end else begin
            next_recv <= RECV_DATA;
            stage     <= FETCH_REQ;
          end
        end
        RECV_DATA, EXECUTE: begin
          next_recv <= RECV_OPCODE;
          stage     <= FETCH_REQ;
        end
        default: stage <= FETCH_REQ;
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/cpu_pkg.sv */
`default_nettype none

package cpu_pkg;

  // Address widths of the two memories
  localparam int RAM_WIDTH  = 13;
  localparam int VRAM_WIDTH = 10;

  typedef logic [7:0]            data_t;
  typedef logic [15:0]           addr_t;
  typedef logic [RAM_WIDTH-1:0]  ram_addr_t;
  typedef logic [VRAM_WIDTH-1:0] vram_addr_t;

  // Memory map
  localparam addr_t PROGRAM_START = 16'h0200;
  localparam addr_t VRAM_START    = 16'hE000;

  // Supported opcodes
  localparam data_t OP_JMP_ABS   = 8'h4C;
  localparam data_t OP_NOP       = 8'hEA;
  localparam data_t OP_LDA_IMM   = 8'hA9;
  localparam data_t OP_LDA_ZP    = 8'hA5;
  localparam data_t OP_LDA_ABS   = 8'hAD;
  localparam data_t OP_LDA_ABS_X = 8'hBD;
  localparam data_t OP_LDA_ABS_Y = 8'hB9;
  localparam data_t OP_LDX_IMM   = 8'hA2;
  localparam data_t OP_LDX_ZP    = 8'hA6;
  localparam data_t OP_LDX_ABS   = 8'hAE;
  localparam data_t OP_LDX_ABS_Y = 8'hBE;
  localparam data_t OP_LDY_IMM   = 8'hA0;
  localparam data_t OP_LDY_ZP    = 8'hA4;
  localparam data_t OP_LDY_ABS   = 8'hAC;
  localparam data_t OP_LDY_ABS_X = 8'hBC;
  localparam data_t OP_STA_ZP    = 8'h85;
  localparam data_t OP_STA_ZP_X  = 8'h95;
  localparam data_t OP_STA_ABS   = 8'h8D;
  localparam data_t OP_STA_ABS_X = 8'h9D;
  localparam data_t OP_STA_ABS_Y = 8'h99;

  // One byte read steps through FETCH_REQ and WAIT_DATA to a RECV stage
  typedef enum logic [2:0] {
    FETCH_REQ,
    WAIT_DATA,
    RECV_OPCODE,
    RECV_OP_LO,
    RECV_OP_HI,
    RECV_DATA,
    EXECUTE
  } fetch_stage_t;

  typedef enum logic [2:0] {
    IMM,
    ZP,
    ZP_X,
    ABS,
    ABS_X,
    ABS_Y,
    IMPLIED
  } addr_mode_t;

  typedef enum logic [1:0] {
    NONE,
    A,
    X,
    Y
  } target_t;

  typedef struct packed {
    addr_mode_t mode;
    target_t    target;
    logic       is_store;
    logic       is_jump;
    logic [1:0] length;
  } decode_t;

  typedef struct packed {
    logic      en;
    ram_addr_t addr;
    data_t     data;
  } ram_wr_t;

  typedef struct packed {
    logic       en;
    vram_addr_t addr;
    data_t      data;
  } vram_wr_t;

endpackage

`default_nettype wire

/* source/cpu_top.sv */
`default_nettype none

module cpu_top (
  input  logic                 clk,
  input  logic                 rst_n,
  input  cpu_pkg::data_t       dout,
  output cpu_pkg::data_t       din,
  output cpu_pkg::ram_addr_t   ada,
  output logic                 cea,
  output logic                 ceb,
  output cpu_pkg::ram_addr_t   adb,
  output cpu_pkg::vram_addr_t  v_ada,
  output logic                 v_cea,
  output cpu_pkg::data_t       v_din
);
  import cpu_pkg::*;

  decode_t    dec;
  logic [1:0] pc_step;
  logic       pc_jump;
  logic       op_lo_load;
  logic       op_hi_load;
  logic       reg_load;
  logic       rd_sel;
  logic       store_go;
  addr_t      pc;
  addr_t      eff_addr;
  data_t      reg_a;
  data_t      reg_x;
  data_t      reg_y;
  ram_wr_t    ram_wr;
  vram_wr_t   vram_wr;

  cpu_control u_control (
    .clk        (clk),
    .rst_n      (rst_n),
    .dout       (dout),
    .dec        (dec),
    .pc_step    (pc_step),
    .pc_jump    (pc_jump),
    .op_lo_load (op_lo_load),
    .op_hi_load (op_hi_load),
    .reg_load   (reg_load),
    .rd_sel     (rd_sel),
    .store_go   (store_go)
  );

  pc_unit u_pc (
    .clk    (clk),
    .rst_n  (rst_n),
    .step   (pc_step),
    .jump   (pc_jump),
    .target (eff_addr),
    .pc     (pc)
  );

  // Immediate operand is the low byte of the effective address
  register_file u_regs (
    .clk     (clk),
    .rst_n   (rst_n),
    .load    (reg_load),
    .target  (dec.target),
    .mode    (dec.mode),
    .operand (eff_addr[7:0]),
    .rd_data (dout),
    .a       (reg_a),
    .x       (reg_x),
    .y       (reg_y)
  );

  address_unit u_addr (
    .clk        (clk),
    .rst_n      (rst_n),
    .dout       (dout),
    .op_lo_load (op_lo_load),
    .op_hi_load (op_hi_load),
    .rd_sel     (rd_sel),
    .store_go   (store_go),
    .mode       (dec.mode),
    .pc         (pc),
    .a          (reg_a),
    .x          (reg_x),
    .y          (reg_y),
    .adb        (adb),
    .target     (eff_addr),
    .ram_wr     (ram_wr),
    .vram_wr    (vram_wr)
  );

  assign din   = ram_wr.data;
  assign ada   = ram_wr.addr;
  assign cea   = ram_wr.en;
  // Read port is always enabled
  assign ceb   = 1'b1;
  assign v_ada = vram_wr.addr;
  assign v_cea = vram_wr.en;
  assign v_din = vram_wr.data;

endmodule

`default_nettype wire

/* source/pc_unit.sv */
`default_nettype none

module pc_unit (
  input  logic           clk,
  input  logic           rst_n,
  input  logic [1:0]     step,
  input  logic           jump,
  input  cpu_pkg::addr_t target,
  output cpu_pkg::addr_t pc
);
  import cpu_pkg::*;

  addr_t stepped;
  addr_t jump_pc;

  // Program space is the 13-bit RAM, so both paths wrap there
  assign stepped = pc + addr_t'(step);
  assign jump_pc = addr_t'(target[RAM_WIDTH-1:0]);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc <= PROGRAM_START;
    end else if (jump) begin
      pc <= jump_pc;
    end else if (step != 2'd0) begin
      pc <= addr_t'(stepped[RAM_WIDTH-1:0]);
    end
  end

endmodule

`default_nettype wire

/* source/register_file.sv */
`default_nettype none

module register_file (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                load,
  input  cpu_pkg::target_t    target,
  input  cpu_pkg::addr_mode_t mode,
  input  cpu_pkg::data_t      operand,
  input  cpu_pkg::data_t      rd_data,
  output cpu_pkg::data_t      a,
  output cpu_pkg::data_t      x,
  output cpu_pkg::data_t      y
);
  import cpu_pkg::*;

  data_t load_val;

  // Immediate loads take the operand byte, all others the memory byte
  assign load_val = (mode == IMM) ? operand : rd_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      a <= '0;
      x <= '0;
      y <= '0;
    end else if (load) begin
      case (target)
        A: a <= load_val;
        X: x <= load_val;
        Y: y <= load_val;
        default: ;
      endcase
    end
  end

endmodule

`default_nettype wire
